/* hdl/rv_decode_stage.sv */
`timescale 1ns/1ps

module rv_decode_stage
	import rv_pipe_pkg::*;
(
	input  logic      clk,
	input  logic      i_arst_n,
	input  if_id_t    i_if_id,
	input  logic      i_stall,
	input  wb_t       i_wb,
	output id_ex_t    o_id_ex,
	output redirect_t o_redirect
);

	dec_t   dec;
	xword_t rs1_val;
	xword_t rs2_val;

	// register read and decode run side by side.
	rv_reg_file u_reg_file (
		.clk       (clk),
		.i_arst_n  (i_arst_n),
		.i_rs1     (dec.rs1),
		.i_rs2     (dec.rs2),
		.i_wb      (i_wb),
		.o_rs1_val (rs1_val),
		.o_rs2_val (rs2_val)
	);

	rv_imm_ctrl_decode u_decode (
		.i_instr (i_if_id.instr),
		.o_dec   (dec)
	);

	rv_id_ex_stage u_id_ex (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_stall    (i_stall),
		.i_if_id    (i_if_id),
		.i_dec      (dec),
		.i_rs1_val  (rs1_val),
		.i_rs2_val  (rs2_val),
		.o_id_ex    (o_id_ex),
		.o_redirect (o_redirect)
	);

endmodule

/* hdl/rv_id_ex_stage.sv */
`timescale 1ns/1ps

module rv_id_ex_stage
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;
(
	input  logic      clk,
	input  logic      i_arst_n,
	input  logic      i_stall,
	input  if_id_t    i_if_id,
	input  dec_t      i_dec,
	input  xword_t    i_rs1_val,
	input  xword_t    i_rs2_val,
	output id_ex_t    o_id_ex,
	output redirect_t o_redirect
);

	id_ex_t id_ex_d;
	id_ex_t id_ex_q;
	logic   valid_q;

	logic   is_jump;
	logic   is_jalr;
	xword_t jump_sum;
	xword_t jump_target;

	logic   redir_valid_q;
	xword_t redir_target_q;

	assign is_jump = i_if_id.valid && (i_dec.iclass == CLS_JUMP);
	assign is_jalr = rv_opcode_e'(i_if_id.instr[OPCODE_W-1:0]) == OPC_JALR;

	// jalr adds to rs1, jal to the pc.
	assign jump_sum    = is_jalr ? (i_rs1_val + i_dec.imm) : (i_if_id.pc + i_dec.imm);
	assign jump_target = {jump_sum[XLEN-1:1], 1'b0};

	always_comb begin
		id_ex_d.valid   = i_if_id.valid;
		id_ex_d.pc      = i_if_id.pc;
		id_ex_d.rs1_val = i_rs1_val;
		id_ex_d.rs2_val = i_rs2_val;
		id_ex_d.imm     = i_dec.imm;
		id_ex_d.rd      = i_dec.rd;
		id_ex_d.rd_we   = i_if_id.valid && i_dec.rd_we;
		id_ex_d.funct3  = i_dec.funct3;
		id_ex_d.funct7  = i_dec.funct7;
		id_ex_d.iclass  = i_dec.iclass;
		id_ex_d.link    = i_if_id.pc + XLEN'(INSTR_BYTES);
	end

	// control state.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_q        <= 1'b0;
			redir_valid_q  <= 1'b0;
			redir_target_q <= BOOT_ADDRESS;
		end else if (i_stall) begin
			redir_valid_q <= 1'b0;
		end else begin
			valid_q       <= id_ex_d.valid;
			redir_valid_q <= is_jump;
			if (is_jump) begin
				redir_target_q <= jump_target;
			end
		end
	end

	// payload, held while stalled.
	always_ff @(posedge clk) begin
		if (!i_stall) begin
			id_ex_q <= id_ex_d;
		end
	end

	always_comb begin
		o_id_ex       = id_ex_q;
		o_id_ex.valid = valid_q;
	end

	assign o_redirect = '{valid: redir_valid_q, target: redir_target_q};

	// fetch flushes on a redirect, so two in a row means a lost flush.
	a_redir_pulse : assert property (
		@(posedge clk) disable iff (!i_arst_n)
		o_redirect.valid |=> !o_redirect.valid
	) else $error("redirect held for two cycles");

	a_redir_align : assert property (
		@(posedge clk) disable iff (!i_arst_n)
		o_redirect.valid |-> !o_redirect.target[0]
	) else $error("redirect target has bit 0 set");

endmodule

/* hdl/rv_imm_ctrl_decode.sv */
`timescale 1ns/1ps

module rv_imm_ctrl_decode
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;
(
	input  logic [XLEN-1:0] i_instr,
	output dec_t            o_dec
);

	rv_opcode_e opcode;
	rv_class_e  iclass;
	reg_idx_t   rd;
	xword_t     imm;
	logic       writes_rd;

	xword_t imm_i;
	xword_t imm_s;
	xword_t imm_b;
	xword_t imm_u;
	xword_t imm_j;

	assign opcode = rv_opcode_e'(i_instr[OPCODE_W-1:0]);
	assign rd     = i_instr[RD_LSB +: REG_ADDR_W];

	// sign-extended immediates, one per format.
	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
	assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0};
	assign imm_u = {i_instr[31:12], 12'b0};
	assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0};

	// unknown opcodes, csr and system fall to illegal.
	always_comb begin
		case (opcode)
			OPC_LUI, OPC_AUIPC: iclass = CLS_UPPER;
			OPC_JAL, OPC_JALR:  iclass = CLS_JUMP;
			OPC_BRANCH:         iclass = CLS_BRANCH;
			OPC_LOAD:           iclass = CLS_LOAD;
			OPC_STORE:          iclass = CLS_STORE;
			OPC_OP_IMM:         iclass = CLS_ALU_IMM;
			OPC_OP:             iclass = CLS_ALU_REG;
			default:            iclass = CLS_ILLEGAL;
		endcase
	end

	// jal and jalr share a class but not a format.
	always_comb begin
		case (opcode)
			OPC_LUI, OPC_AUIPC:             imm = imm_u;
			OPC_JAL:                        imm = imm_j;
			OPC_JALR, OPC_LOAD, OPC_OP_IMM: imm = imm_i;
			OPC_STORE:                      imm = imm_s;
			OPC_BRANCH:                     imm = imm_b;
			default:                        imm = '0;
		endcase
	end

	always_comb begin
		case (iclass)
			CLS_UPPER, CLS_JUMP, CLS_LOAD, CLS_ALU_IMM, CLS_ALU_REG: writes_rd = 1'b1;
			default:                                                 writes_rd = 1'b0;
		endcase
	end

	always_comb begin
		o_dec.iclass = iclass;
		o_dec.rs1    = i_instr[RS1_LSB +: REG_ADDR_W];
		o_dec.rs2    = i_instr[RS2_LSB +: REG_ADDR_W];
		o_dec.rd     = rd;
		o_dec.funct3 = i_instr[FUNCT3_LSB +: FUNCT3_W];
		o_dec.funct7 = i_instr[FUNCT7_LSB +: FUNCT7_W];
		o_dec.imm    = imm;
		// writes to x0 are dropped here already.
		o_dec.rd_we  = writes_rd && (rd != '0);
	end

endmodule

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

	// data path and address width.
	localparam int XLEN = 32;

	// register file geometry.
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	// instruction word field widths.
	localparam int OPCODE_W = 7;
	localparam int FUNCT3_W = 3;
	localparam int FUNCT7_W = 7;
	localparam int CLASS_W  = 3;

	// field positions inside the instruction word.
	localparam int RD_LSB     = 7;
	localparam int FUNCT3_LSB = 12;
	localparam int RS1_LSB    = 15;
	localparam int RS2_LSB    = 20;
	localparam int FUNCT7_LSB = 25;

	// size of one instruction in bytes, used for the link value.
	localparam int INSTR_BYTES = 4;

	// reset value of the redirect target.
	localparam logic [XLEN-1:0] BOOT_ADDRESS = 32'h0000_0000;

	// base opcodes of the rv32i subset handled here.
	typedef enum logic [OPCODE_W-1:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} rv_opcode_e;

	// coarse class handed to execute.
	typedef enum logic [CLASS_W-1:0] {
		CLS_UPPER   = 3'd0,
		CLS_JUMP    = 3'd1,
		CLS_BRANCH  = 3'd2,
		CLS_LOAD    = 3'd3,
		CLS_STORE   = 3'd4,
		CLS_ALU_IMM = 3'd5,
		CLS_ALU_REG = 3'd6,
		CLS_ILLEGAL = 3'd7
	} rv_class_e;

endpackage

/* hdl/rv_pipe_pkg.sv */
package rv_pipe_pkg;

	import rv_isa_pkg::*;

	typedef logic [XLEN-1:0]       xword_t;
	typedef logic [REG_ADDR_W-1:0] reg_idx_t;

	// fetch/decode register contents.
	typedef struct packed {
		logic   valid;
		xword_t pc;
		xword_t instr;
	} if_id_t;

	// writeback port into the register file.
	typedef struct packed {
		logic     we;
		reg_idx_t rd;
		xword_t   data;
	} wb_t;

	// decoder result.
	typedef struct packed {
		rv_class_e           iclass;
		reg_idx_t            rs1;
		reg_idx_t            rs2;
		reg_idx_t            rd;
		logic [FUNCT3_W-1:0] funct3;
		logic [FUNCT7_W-1:0] funct7;
		xword_t              imm;
		logic                rd_we;
	} dec_t;

	// decode/execute register contents.
	typedef struct packed {
		logic                valid;
		xword_t              pc;
		xword_t              rs1_val;
		xword_t              rs2_val;
		xword_t              imm;
		reg_idx_t            rd;
		logic                rd_we;
		logic [FUNCT3_W-1:0] funct3;
		logic [FUNCT7_W-1:0] funct7;
		rv_class_e           iclass;
		xword_t              link;
	} id_ex_t;

	typedef struct packed {
		logic   valid;
		xword_t target;
	} redirect_t;

endpackage

/* hdl/rv_reg_file.sv */
`timescale 1ns/1ps

module rv_reg_file
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;
(
	input  logic     clk,
	input  logic     i_arst_n,
	input  reg_idx_t i_rs1,
	input  reg_idx_t i_rs2,
	input  wb_t      i_wb,
	output xword_t   o_rs1_val,
	output xword_t   o_rs2_val
);

	// x0 has no storage.
	xword_t regs [1:NUM_REGS-1];

	logic wr_en;

	assign wr_en = i_wb.we && (i_wb.rd != '0);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[i_wb.rd] <= i_wb.data;
		end
	end

	// one read port, with the pending write forwarded.
	function automatic xword_t read_port(input reg_idx_t idx);
		xword_t val;
		if (idx == '0) begin
			val = '0;
		end else if (wr_en && (i_wb.rd == idx)) begin
			val = i_wb.data;
		end else begin
			val = regs[idx];
		end
		return val;
	endfunction

	always_comb begin
		o_rs1_val = read_port(i_rs1);
		o_rs2_val = read_port(i_rs2);
	end

	// a write aimed at x0 must never show up on a later read.
	a_x0_zero : assert property (
		@(posedge clk) disable iff (!i_arst_n)
		((i_rs1 == '0) |-> (o_rs1_val == '0)) and ((i_rs2 == '0) |-> (o_rs2_val == '0))
	) else $error("x0 read back non-zero");

	a_wr_visible : assert property (
		@(posedge clk) disable iff (!i_arst_n)
		wr_en |=> (i_rs1 != $past(i_wb.rd)) || (i_wb.we && i_wb.rd == i_rs1) ||
			(o_rs1_val == $past(i_wb.data))
	) else $error("written value not visible on the next read");

endmodule

/* rv_decode_stage.f */
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_reg_file.sv
hdl/rv_imm_ctrl_decode.sv
hdl/rv_id_ex_stage.sv
hdl/rv_decode_stage.sv
sim/tb_rv_decode_stage.sv

/* sim/tb_rv_decode_stage.sv */
`timescale 1ns/1ps

module tb_rv_decode_stage
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;
();

	localparam int MAX_WAIT = 8;

	logic      clk;
	logic      i_arst_n;
	if_id_t    i_if_id;
	logic      i_stall;
	wb_t       i_wb;
	id_ex_t    o_id_ex;
	redirect_t o_redirect;

	// shadow copy of the register file.
	xword_t    shadow [0:NUM_REGS-1];
	xword_t    next_pc;
	id_ex_t    last_exp;
	redirect_t none;

	rv_decode_stage uut (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_if_id    (i_if_id),
		.i_stall    (i_stall),
		.i_wb       (i_wb),
		.o_id_ex    (o_id_ex),
		.o_redirect (o_redirect)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic compare_word(input string name, input xword_t got, input xword_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_id_ex(input id_ex_t exp);
		compare_word("o_id_ex.valid", xword_t'(o_id_ex.valid), xword_t'(exp.valid));
		if (exp.valid) begin
			compare_word("o_id_ex.pc", o_id_ex.pc, exp.pc);
			compare_word("o_id_ex.rs1_val", o_id_ex.rs1_val, exp.rs1_val);
			compare_word("o_id_ex.rs2_val", o_id_ex.rs2_val, exp.rs2_val);
			compare_word("o_id_ex.imm", o_id_ex.imm, exp.imm);
			compare_word("o_id_ex.rd", xword_t'(o_id_ex.rd), xword_t'(exp.rd));
			compare_word("o_id_ex.rd_we", xword_t'(o_id_ex.rd_we), xword_t'(exp.rd_we));
			compare_word("o_id_ex.funct3", xword_t'(o_id_ex.funct3), xword_t'(exp.funct3));
			compare_word("o_id_ex.funct7", xword_t'(o_id_ex.funct7), xword_t'(exp.funct7));
			compare_word("o_id_ex.iclass", xword_t'(o_id_ex.iclass), xword_t'(exp.iclass));
			compare_word("o_id_ex.link", o_id_ex.link, exp.link);
		end
	endtask

	task automatic check_redirect(input redirect_t exp, input bit with_target);
		compare_word("o_redirect.valid", xword_t'(o_redirect.valid), xword_t'(exp.valid));
		if (exp.valid || with_target) begin
			compare_word("o_redirect.target", o_redirect.target, exp.target);
		end
	endtask

	// instruction words per format.
	function automatic xword_t r_type_word(input logic [6:0] f7, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd, input rv_opcode_e opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic xword_t i_type_word(input int imm, input reg_idx_t rs1,
		input logic [2:0] f3, input reg_idx_t rd, input rv_opcode_e opc);
		return {imm[11:0], rs1, f3, rd, opc};
	endfunction

	function automatic xword_t s_type_word(input int imm, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3, input rv_opcode_e opc);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
	endfunction

	function automatic xword_t b_type_word(input int imm, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3, input rv_opcode_e opc);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
	endfunction

	function automatic xword_t u_type_word(input xword_t imm, input reg_idx_t rd,
		input rv_opcode_e opc);
		return {imm[31:12], rd, opc};
	endfunction

	function automatic xword_t j_type_word(input int imm, input reg_idx_t rd,
		input rv_opcode_e opc);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
	endfunction

	// reads see a write landing in the same cycle.
	function automatic xword_t model_read(input reg_idx_t idx);
		xword_t val;
		if (idx == '0) begin
			val = '0;
		end else if (i_wb.we && i_wb.rd == idx) begin
			val = i_wb.data;
		end else begin
			val = shadow[idx];
		end
		return val;
	endfunction

	function automatic id_ex_t expected_id_ex(input xword_t pc, input xword_t instr,
		input xword_t imm, input rv_class_e cls, input logic we);
		id_ex_t e;
		e.valid   = 1'b1;
		e.pc      = pc;
		e.rs1_val = model_read(instr[19:15]);
		e.rs2_val = model_read(instr[24:20]);
		e.imm     = imm;
		e.rd      = instr[11:7];
		e.rd_we   = we;
		e.funct3  = instr[14:12];
		e.funct7  = instr[31:25];
		e.iclass  = cls;
		e.link    = pc + 32'd4;
		return e;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		if (i_wb.we && i_wb.rd != '0) begin
			shadow[i_wb.rd] = i_wb.data;
		end
		@(negedge clk);
	endtask

	task automatic drive_idle();
		i_if_id = '0;
		i_wb    = '0;
		i_stall = 1'b0;
	endtask

	task automatic write_reg(input reg_idx_t rd, input xword_t data);
		i_wb = '{we: 1'b1, rd: rd, data: data};
		next_cycle();
		i_wb = '0;
	endtask

	task automatic await_output(input id_ex_t exp, input redirect_t exp_r);
		int lat;
		next_cycle();
		drive_idle();
		lat = 1;
		while (!(o_id_ex.valid === 1'b1 && o_id_ex.pc === exp.pc)) begin
			if (lat >= MAX_WAIT) begin
				stop_on_error($sformatf("timeout: no output for pc %h after %0d cycles",
					exp.pc, lat));
			end
			next_cycle();
			lat++;
		end
		if (lat != 1) begin
			stop_on_error($sformatf("output for pc %h came %0d cycles after acceptance",
				exp.pc, lat));
		end
		check_id_ex(exp);
		check_redirect(exp_r, 1'b0);
		last_exp = exp;
	endtask

	task automatic issue(input xword_t instr, input xword_t imm, input rv_class_e cls,
		input logic we, input redirect_t exp_r);
		xword_t pc;
		pc       = next_pc;
		next_pc += 32'd4;
		i_if_id  = '{valid: 1'b1, pc: pc, instr: instr};
		await_output(expected_id_ex(pc, instr, imm, cls, we), exp_r);
	endtask

	task automatic test_reset();
		id_ex_t exp;
		exp = '0;
		check_id_ex(exp);
		check_redirect('{valid: 1'b0, target: BOOT_ADDRESS}, 1'b1);
	endtask

	task automatic test_reg_file();
		reg_idx_t rd;
		// registers come out of reset cleared.
		issue(r_type_word(7'd0, 5'd25, 5'd7, 3'd0, 5'd1, OPC_OP), '0, CLS_ALU_REG, 1'b1, none);
		for (int i = 1; i < NUM_REGS; i++) begin
			write_reg(reg_idx_t'(i), $urandom());
		end
		write_reg('0, $urandom());
		for (int i = 0; i < NUM_REGS; i++) begin
			rd = reg_idx_t'($urandom_range(31, 1));
			issue(r_type_word(7'd0, reg_idx_t'(31 - i), reg_idx_t'(i), 3'd0, rd, OPC_OP),
				'0, CLS_ALU_REG, 1'b1, none);
		end
		// write and read of x12 in one cycle.
		i_wb = '{we: 1'b1, rd: 5'd12, data: $urandom()};
		issue(r_type_word(7'd0, 5'd12, 5'd12, 3'd0, 5'd1, OPC_OP), '0, CLS_ALU_REG, 1'b1, none);
		i_wb = '{we: 1'b1, rd: 5'd0, data: 32'hdead_beef};
		issue(r_type_word(7'd0, 5'd0, 5'd0, 3'd0, 5'd2, OPC_OP), '0, CLS_ALU_REG, 1'b1, none);
	endtask

	task automatic test_imm_class();
		issue(u_type_word(32'habcd_e000, 5'd3, OPC_LUI), 32'habcd_e000, CLS_UPPER, 1'b1, none);
		issue(u_type_word(32'h8000_1000, 5'd4, OPC_AUIPC), 32'h8000_1000, CLS_UPPER, 1'b1, none);
		issue(i_type_word(-5, 5'd6, 3'd0, 5'd5, OPC_OP_IMM), -5, CLS_ALU_IMM, 1'b1, none);
		issue(i_type_word(-12, 5'd8, 3'd2, 5'd7, OPC_LOAD), -12, CLS_LOAD, 1'b1, none);
		issue(s_type_word(2044, 5'd9, 5'd10, 3'd2, OPC_STORE), 2044, CLS_STORE, 1'b0, none);
		issue(s_type_word(-100, 5'd3, 5'd4, 3'd0, OPC_STORE), -100, CLS_STORE, 1'b0, none);
		issue(b_type_word(-16, 5'd2, 5'd1, 3'd0, OPC_BRANCH), -16, CLS_BRANCH, 1'b0, none);
		issue(b_type_word(2000, 5'd5, 5'd6, 3'd1, OPC_BRANCH), 2000, CLS_BRANCH, 1'b0, none);
		issue(r_type_word(7'h20, 5'd13, 5'd12, 3'd0, 5'd11, OPC_OP), '0, CLS_ALU_REG, 1'b1, none);
		// rd of x0 never writes.
		issue(r_type_word(7'd0, 5'd1, 5'd2, 3'd0, 5'd0, OPC_OP), '0, CLS_ALU_REG, 1'b0, none);
	endtask

	task automatic test_jumps();
		xword_t base;
		issue(j_type_word(2048, 5'd1, OPC_JAL), 2048, CLS_JUMP, 1'b1,
			'{valid: 1'b1, target: next_pc + 32'd2048});
		next_cycle();
		check_redirect(none, 1'b0);
		next_pc = 32'h0000_1000;
		issue(j_type_word(-256, 5'd0, OPC_JAL), -256, CLS_JUMP, 1'b0,
			'{valid: 1'b1, target: 32'h0000_0f00});
		next_cycle();
		check_redirect(none, 1'b0);
		// even base plus odd offset gives an odd sum.
		base = $urandom() & ~32'd1;
		write_reg(5'd10, base);
		issue(i_type_word(7, 5'd10, 3'd0, 5'd1, OPC_JALR), 7, CLS_JUMP, 1'b1,
			'{valid: 1'b1, target: (base + 32'd7) & ~32'd1});
		next_cycle();
		check_redirect(none, 1'b0);
	endtask

	task automatic test_stall();
		id_ex_t held;
		xword_t pc;
		xword_t word;
		issue(i_type_word(100, 5'd2, 3'd0, 5'd3, OPC_OP_IMM), 100, CLS_ALU_IMM, 1'b1, none);
		held     = last_exp;
		pc       = next_pc;
		next_pc += 32'd4;
		word     = j_type_word(-8, 5'd1, OPC_JAL);
		i_if_id  = '{valid: 1'b1, pc: pc, instr: word};
		i_stall  = 1'b1;
		repeat (3) begin
			next_cycle();
			check_id_ex(held);
			check_redirect(none, 1'b0);
		end
		i_stall = 1'b0;
		await_output(expected_id_ex(pc, word, -8, CLS_JUMP, 1'b1),
			'{valid: 1'b1, target: pc - 32'd8});
	endtask

	task automatic test_illegal();
		id_ex_t exp;
		issue({12'h000, 5'd0, 3'd0, 5'd5, 7'b1110011}, '0, CLS_ILLEGAL, 1'b0, none);
		issue({12'h123, 5'd4, 3'd1, 5'd6, 7'b0001011}, '0, CLS_ILLEGAL, 1'b0, none);
		// a jump without valid must not redirect.
		i_if_id = '{valid: 1'b0, pc: next_pc, instr: j_type_word(64, 5'd1, OPC_JAL)};
		next_cycle();
		drive_idle();
		exp = '0;
		check_id_ex(exp);
		check_redirect(none, 1'b0);
	endtask

	initial begin
		void'($urandom(33));
		i_arst_n = 1'b0;
		drive_idle();
		none     = '0;
		next_pc  = 32'h0000_0100;
		for (int i = 0; i < NUM_REGS; i++) begin
			shadow[i] = '0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		i_arst_n = 1'b1;
		test_reset();
		test_reg_file();
		test_imm_class();
		test_jumps();
		test_stall();
		test_illegal();
		$display("all tests passed");
		$finish;
	end

endmodule
